// ==== tetrisPkg.sv ====
// shared definitions for the falling-block game core
// board geometry, game FSM states and keyboard codes

package tetrisPkg;

	// ==============================
	// board geometry
	// ==============================

	// width of the board in cells
	localparam int BoardCols = 10;
	// height of the board in cells
	localparam int BoardRows = 20;
	// colour index per cell, 0 is an empty cell
	localparam int CellBits = 4;
	// one whole board row, cell 0 in the low bits
	localparam int RowBits = BoardCols * CellBits;
	// enough for rows 0..19
	localparam int RowAddrBits = 5;

	// ==============================
	// game FSM
	// ==============================

	typedef enum logic [3:0] {
		Clear,
		Spawn,
		Idle,
		Move,
		Fall,
		Lock,
		Scan,
		Shift,
		Over
	} gameState_t;

	// ==============================
	// USB HID keycodes
	// ==============================

	// A, D and S as on the keyboard
	typedef enum logic [7:0] {
		KeyNone  = 8'h00,
		KeyLeft  = 8'h04,
		KeyRight = 8'h07,
		KeyDrop  = 8'h16
	} keyCode_t;

endpackage

// ==== vgaTiming.sv ====
// VGA raster timing
// pixel and line counters, sync pulses and visible flag

`timescale 1ns/1ps

module vgaTiming #(
	parameter int HVisible = 640,
	parameter int HFront = 16,
	parameter int HSync = 96,
	parameter int HBack = 48,
	parameter int VVisible = 480,
	parameter int VFront = 10,
	parameter int VSync = 2,
	parameter int VBack = 33
) (
	input  logic       Clk,
	input  logic       rst,
	output logic       hs,
	output logic       vs,
	output logic       visible,
	output logic [9:0] DrawX,
	output logic [9:0] DrawY
);

	localparam int HTotal = HVisible + HFront + HSync + HBack;
	localparam int VTotal = VVisible + VFront + VSync + VBack;

	logic [9:0] hNext;
	logic [9:0] vNext;

	// next raster position
	// line wraps at HTotal, frame wraps at VTotal
	always_comb begin
		hNext = DrawX + 10'd1;
		vNext = DrawY;
		if (DrawX == 10'(HTotal - 1)) begin
			hNext = '0;
			if (DrawY == 10'(VTotal - 1))
				vNext = '0;
			else
				vNext = DrawY + 10'd1;
		end
	end

	// sync and visible decoded from the next position
	// so they line up with the counters
	always_ff @(posedge Clk) begin
		if (rst) begin
			DrawX <= '0;
			DrawY <= '0;
			hs <= 1'b1;
			vs <= 1'b1;
			// position 0,0 is the first visible pixel
			visible <= 1'b1;
		end else begin
			DrawX <= hNext;
			DrawY <= vNext;
			// sync pulses are active low
			hs <= !(hNext >= HVisible + HFront && hNext < HVisible + HFront + HSync);
			vs <= !(vNext >= VVisible + VFront && vNext < VVisible + VFront + VSync);
			visible <= (hNext < HVisible) && (vNext < VVisible);
		end
	end

endmodule

// ==== boardRam.sv ====
// board memory of locked cells
// game port with read and write, display port read only

`timescale 1ns/1ps

module boardRam (
	input  logic                             Clk,
	input  logic                             rst,
	input  logic [tetrisPkg::RowAddrBits-1:0] gameRow,
	output logic [tetrisPkg::RowBits-1:0]     gameRowData,
	input  logic                             gameWrite,
	input  logic [tetrisPkg::RowAddrBits-1:0] gameWrRow,
	input  logic [tetrisPkg::RowBits-1:0]     gameWrData,
	input  logic [tetrisPkg::RowAddrBits-1:0] dispRow,
	output logic [tetrisPkg::RowBits-1:0]     dispRowData
);

	import tetrisPkg::*;

	// one word per board row
	logic [RowBits-1:0] mem [BoardRows];

	// single write port, owned by the game
	always_ff @(posedge Clk) begin
		if (gameWrite && gameWrRow < BoardRows)
			mem[gameWrRow] <= gameWrData;
	end

	// both reads are registered, data one clock after the address
	// rows past the bottom read as empty
	always_ff @(posedge Clk) begin
		if (rst) begin
			gameRowData <= '0;
			dispRowData <= '0;
		end else begin
			if (gameRow < BoardRows)
				gameRowData <= mem[gameRow];
			else
				gameRowData <= '0;
			if (dispRow < BoardRows)
				dispRowData <= mem[dispRow];
			else
				dispRowData <= '0;
		end
	end

endmodule

// ==== gameLogic.sv ====
// game FSM for the 2x2 piece
// spawn, move, gravity, lock, row clear, score and game over

`timescale 1ns/1ps

module gameLogic #(
	parameter int FallDiv = 30
) (
	input  logic                              Clk,
	input  logic                              rst,
	input  logic                              vs,
	input  logic [7:0]                        keycode,
	output logic [tetrisPkg::RowAddrBits-1:0] gameRow,
	input  logic [tetrisPkg::RowBits-1:0]     gameRowData,
	output logic                              gameWrite,
	output logic [tetrisPkg::RowAddrBits-1:0] gameWrRow,
	output logic [tetrisPkg::RowBits-1:0]     gameWrData,
	output logic [3:0]                        pieceX,
	output logic [tetrisPkg::RowAddrBits-1:0] pieceY,
	output logic [tetrisPkg::CellBits-1:0]    pieceColor,
	output logic [7:0]                        score,
	output logic                              gameOver
);

	import tetrisPkg::*;

	localparam logic [3:0] SpawnX = 4'd4;
	// rightmost legal column of the left half
	localparam logic [3:0] MaxX = 4'(BoardCols - 2);
	localparam logic [RowAddrBits-1:0] LastRow = RowAddrBits'(BoardRows - 1);

	gameState_t state;
	keyCode_t key;
	logic [1:0] step;
	logic [RowAddrBits-1:0] rowPtr;
	logic [RowAddrBits-1:0] shiftRow;
	logic [3:0] moveX;
	logic [7:0] frameCnt;
	logic fallDue;
	logic vsPrev;
	logic tick;
	logic [RowBits-1:0] rowA;

	assign key = keyCode_t'(keycode);
	// frame tick on vs falling edge, inside vertical blanking
	assign tick = vsPrev && !vs;

	// ==============================
	// row helpers
	// ==============================

	function automatic logic [CellBits-1:0] cellOf(input logic [RowBits-1:0] r, input int col);
		return r[col*CellBits +: CellBits];
	endfunction

	// both cells at col and col+1 empty
	function automatic logic pairFree(input logic [RowBits-1:0] r, input logic [3:0] col);
		return (cellOf(r, col) == '0) && (cellOf(r, col + 1) == '0);
	endfunction

	function automatic logic rowFull(input logic [RowBits-1:0] r);
		logic full;
		full = 1'b1;
		for (int c = 0; c < BoardCols; c++) begin
			if (cellOf(r, c) == '0)
				full = 1'b0;
		end
		return full;
	endfunction

	// drop the piece colour into two neighbouring cells
	function automatic logic [RowBits-1:0] mergePiece(input logic [RowBits-1:0] r,
			input logic [3:0] col, input logic [CellBits-1:0] color);
		logic [RowBits-1:0] merged;
		merged = r;
		merged[col*CellBits +: CellBits] = color;
		merged[(col+1)*CellBits +: CellBits] = color;
		return merged;
	endfunction

	// ==============================
	// board port
	// ==============================

	always_comb begin
		gameRow = '0;
		gameWrite = 1'b0;
		gameWrRow = '0;
		gameWrData = '0;
		unique case (state)
			// zero row per clock
			Clear: begin
				gameWrite = 1'b1;
				gameWrRow = rowPtr;
			end
			Spawn: gameRow = (step == 2'd0) ? '0 : RowAddrBits'(1);
			Move: gameRow = (step == 2'd0) ? pieceY : pieceY + 1'b1;
			// row just under the piece
			Fall: gameRow = pieceY + RowAddrBits'(2);
			Lock: begin
				gameRow = (step == 2'd0) ? pieceY : pieceY + 1'b1;
				if (step != 2'd0) begin
					gameWrite = 1'b1;
					gameWrRow = (step == 2'd1) ? pieceY : pieceY + 1'b1;
					gameWrData = mergePiece(gameRowData, pieceX, pieceColor);
				end
			end
			Scan: gameRow = rowPtr;
			Shift: begin
				gameRow = shiftRow - 1'b1;
				// top row gets zeros, others get the row above
				if (step == 2'd0 && shiftRow == '0) begin
					gameWrite = 1'b1;
					gameWrRow = '0;
				end else if (step == 2'd1) begin
					gameWrite = 1'b1;
					gameWrRow = shiftRow;
					gameWrData = gameRowData;
				end
			end
			default: gameRow = '0;
		endcase
	end

	// ==============================
	// FSM
	// ==============================

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= Clear;
			step <= '0;
			rowPtr <= '0;
			shiftRow <= '0;
			frameCnt <= '0;
			fallDue <= 1'b0;
			vsPrev <= 1'b1;
			pieceX <= SpawnX;
			pieceY <= '0;
			pieceColor <= CellBits'(1);
			score <= '0;
			gameOver <= 1'b0;
		end else begin
			vsPrev <= vs;
			unique case (state)
				Clear: begin
					rowPtr <= rowPtr + 1'b1;
					if (rowPtr == LastRow) begin
						state <= Spawn;
						step <= '0;
					end
				end
				// two reads, decide on the third clock
				Spawn: begin
					step <= step + 1'b1;
					if (step == 2'd1)
						rowA <= gameRowData;
					if (step == 2'd2) begin
						step <= '0;
						if (pairFree(rowA, SpawnX) && pairFree(gameRowData, SpawnX)) begin
							pieceX <= SpawnX;
							pieceY <= '0;
							state <= Idle;
						end else begin
							gameOver <= 1'b1;
							state <= Over;
						end
					end
				end
				Idle: begin
					if (tick) begin
						step <= '0;
						// gravity counter runs on every tick
						fallDue <= (key == KeyDrop) || (frameCnt == 8'(FallDiv - 1));
						if (frameCnt == 8'(FallDiv - 1))
							frameCnt <= '0;
						else
							frameCnt <= frameCnt + 1'b1;
						if (key == KeyLeft && pieceX != '0) begin
							moveX <= pieceX - 1'b1;
							state <= Move;
						end else if (key == KeyRight && pieceX < MaxX) begin
							moveX <= pieceX + 1'b1;
							state <= Move;
						end else begin
							state <= Fall;
						end
					end
				end
				Move: begin
					step <= step + 1'b1;
					if (step == 2'd1)
						rowA <= gameRowData;
					if (step == 2'd2) begin
						step <= '0;
						if (pairFree(rowA, moveX) && pairFree(gameRowData, moveX))
							pieceX <= moveX;
						state <= Fall;
					end
				end
				Fall: begin
					if (step == 2'd0) begin
						if (!fallDue)
							state <= Idle;
						else if (pieceY == LastRow - 1'b1)
							state <= Lock;
						else
							step <= 2'd1;
					end else begin
						step <= '0;
						if (pairFree(gameRowData, pieceX)) begin
							pieceY <= pieceY + 1'b1;
							state <= Idle;
						end else begin
							state <= Lock;
						end
					end
				end
				// writes happen in the port logic on steps 1 and 2
				Lock: begin
					step <= step + 1'b1;
					if (step == 2'd2) begin
						step <= '0;
						rowPtr <= LastRow;
						state <= Scan;
					end
				end
				// bottom-up, a cleared row is checked again
				Scan: begin
					step <= step + 1'b1;
					if (step == 2'd1) begin
						step <= '0;
						if (rowFull(gameRowData)) begin
							score <= score + 1'b1;
							shiftRow <= rowPtr;
							state <= Shift;
						end else if (rowPtr == '0) begin
							// next colour, 1..7
							if (pieceColor == CellBits'(7))
								pieceColor <= CellBits'(1);
							else
								pieceColor <= pieceColor + 1'b1;
							state <= Spawn;
						end else begin
							rowPtr <= rowPtr - 1'b1;
						end
					end
				end
				// read row above, write it one lower
				Shift: begin
					if (step == 2'd0) begin
						if (shiftRow == '0)
							state <= Scan;
						else
							step <= 2'd1;
					end else begin
						shiftRow <= shiftRow - 1'b1;
						step <= '0;
					end
				end
				// held until reset
				Over: gameOver <= 1'b1;
				default: state <= Over;
			endcase
		end
	end

endmodule

// ==== colorMapper.sv ====
// pixel colour from the board row buffer
// piece overlay and 4-bit palette

`timescale 1ns/1ps

module colorMapper #(
	parameter int CellShift = 4
) (
	input  logic                              Clk,
	input  logic                              rst,
	input  logic                              hs,
	input  logic                              visible,
	input  logic [9:0]                        DrawX,
	input  logic [9:0]                        DrawY,
	output logic [tetrisPkg::RowAddrBits-1:0] dispRow,
	input  logic [tetrisPkg::RowBits-1:0]     dispRowData,
	input  logic [3:0]                        pieceX,
	input  logic [tetrisPkg::RowAddrBits-1:0] pieceY,
	input  logic [tetrisPkg::CellBits-1:0]    pieceColor,
	output logic [3:0]                        Red,
	output logic [3:0]                        Green,
	output logic [3:0]                        Blue
);

	import tetrisPkg::*;

	logic hsPrev;
	logic [1:0] loadPipe;
	logic [RowBits-1:0] rowBuf;
	logic [10:0] nextRow;
	logic [9:0] cellX;
	logic [9:0] cellY;
	logic inBoard;
	logic inPiece;
	logic [CellBits-1:0] pixIdx;
	logic [11:0] rgbNext;

	// ==============================
	// row fetch
	// ==============================

	// board row of the coming line
	assign nextRow = (11'(DrawY) + 11'd1) >> CellShift;

	// address on hs fall, data back one clock later, latch after that
	always_ff @(posedge Clk) begin
		if (rst) begin
			hsPrev <= 1'b1;
			loadPipe <= '0;
			dispRow <= '0;
			rowBuf <= '0;
		end else begin
			hsPrev <= hs;
			loadPipe <= {loadPipe[0], hsPrev && !hs};
			if (hsPrev && !hs) begin
				// below the board, park on row 0 for the next frame
				if (nextRow < BoardRows)
					dispRow <= nextRow[RowAddrBits-1:0];
				else
					dispRow <= '0;
			end
			if (loadPipe[1])
				rowBuf <= dispRowData;
		end
	end

	// ==============================
	// pixel
	// ==============================

	assign cellX = DrawX >> CellShift;
	assign cellY = DrawY >> CellShift;
	assign inBoard = (cellX < BoardCols) && (cellY < BoardRows);
	assign inPiece = (cellX >= pieceX) && (cellX <= pieceX + 1'b1) &&
			(cellY >= pieceY) && (cellY <= pieceY + 1'b1);

	always_comb begin
		pixIdx = '0;
		if (visible && inBoard) begin
			pixIdx = rowBuf[cellX[3:0]*CellBits +: CellBits];
			// active piece drawn on top
			if (inPiece)
				pixIdx = pieceColor;
		end
	end

	// palette, seven colours and black
	always_comb begin
		unique case (pixIdx)
			4'd1: rgbNext = 12'h0FF;
			4'd2: rgbNext = 12'hFF0;
			4'd3: rgbNext = 12'hA0F;
			4'd4: rgbNext = 12'h0F0;
			4'd5: rgbNext = 12'hF00;
			4'd6: rgbNext = 12'h00F;
			4'd7: rgbNext = 12'hF80;
			default: rgbNext = 12'h000;
		endcase
	end

	// one clock behind DrawX
	always_ff @(posedge Clk) begin
		if (rst) begin
			Red <= '0;
			Green <= '0;
			Blue <= '0;
		end else begin
			Red <= rgbNext[11:8];
			Green <= rgbNext[7:4];
			Blue <= rgbNext[3:0];
		end
	end

endmodule

// ==== hexDriver.sv ====
// hex digit to seven-segment decoder, segments active low

`timescale 1ns/1ps

module hexDriver (
	input  logic [3:0] In0,
	output logic [6:0] Out0
);

	// bit 0 is segment a, bit 6 is segment g
	always_comb begin
		unique case (In0)
			4'h0: Out0 = 7'b1000000;
			4'h1: Out0 = 7'b1111001;
			4'h2: Out0 = 7'b0100100;
			4'h3: Out0 = 7'b0110000;
			4'h4: Out0 = 7'b0011001;
			4'h5: Out0 = 7'b0010010;
			4'h6: Out0 = 7'b0000010;
			4'h7: Out0 = 7'b1111000;
			4'h8: Out0 = 7'b0000000;
			4'h9: Out0 = 7'b0010000;
			4'hA: Out0 = 7'b0001000;
			4'hB: Out0 = 7'b0000011;
			4'hC: Out0 = 7'b1000110;
			4'hD: Out0 = 7'b0100001;
			4'hE: Out0 = 7'b0000110;
			default: Out0 = 7'b0001110;
		endcase
	end

endmodule

// ==== tetrisTop.sv ====
// top level of the game core
// VGA timing, game FSM, board memory, colour mapper and score digits

`timescale 1ns/1ps

module tetrisTop #(
	parameter int HVisible = 640,
	parameter int HFront = 16,
	parameter int HSync = 96,
	parameter int HBack = 48,
	parameter int VVisible = 480,
	parameter int VFront = 10,
	parameter int VSync = 2,
	parameter int VBack = 33,
	parameter int CellShift = 4,
	parameter int FallDiv = 30
) (
	input  logic       MAX10_CLK1_50,
	input  logic       rst,
	input  logic [7:0] keycode,
	output logic [9:0] LEDR,
	output logic [7:0] HEX0,
	output logic [7:0] HEX1,
	output logic       VGA_HS,
	output logic       VGA_VS,
	output logic [3:0] VGA_R,
	output logic [3:0] VGA_G,
	output logic [3:0] VGA_B
);

	import tetrisPkg::*;

	logic [9:0] drawX;
	logic [9:0] drawY;
	logic visible;
	logic [RowAddrBits-1:0] gameRow;
	logic [RowAddrBits-1:0] gameWrRow;
	logic [RowAddrBits-1:0] dispRow;
	logic [RowBits-1:0] gameRowData;
	logic [RowBits-1:0] gameWrData;
	logic [RowBits-1:0] dispRowData;
	logic gameWrite;
	logic [3:0] pieceX;
	logic [RowAddrBits-1:0] pieceY;
	logic [CellBits-1:0] pieceColor;
	logic [7:0] score;
	logic gameOver;

	// ==============================
	// video and game
	// ==============================

	vgaTiming #(
		.HVisible(HVisible), .HFront(HFront), .HSync(HSync), .HBack(HBack),
		.VVisible(VVisible), .VFront(VFront), .VSync(VSync), .VBack(VBack)
	) vgaTiming_i (
		.Clk(MAX10_CLK1_50), .rst(rst), .hs(VGA_HS), .vs(VGA_VS),
		.visible(visible), .DrawX(drawX), .DrawY(drawY)
	);

	// game steps once per frame on VGA_VS
	gameLogic #(.FallDiv(FallDiv)) gameLogic_i (
		.Clk(MAX10_CLK1_50), .rst(rst), .vs(VGA_VS), .keycode(keycode),
		.gameRow(gameRow), .gameRowData(gameRowData), .gameWrite(gameWrite),
		.gameWrRow(gameWrRow), .gameWrData(gameWrData), .pieceX(pieceX),
		.pieceY(pieceY), .pieceColor(pieceColor), .score(score), .gameOver(gameOver)
	);

	boardRam boardRam_i (
		.Clk(MAX10_CLK1_50), .rst(rst), .gameRow(gameRow), .gameRowData(gameRowData),
		.gameWrite(gameWrite), .gameWrRow(gameWrRow), .gameWrData(gameWrData),
		.dispRow(dispRow), .dispRowData(dispRowData)
	);

	colorMapper #(.CellShift(CellShift)) colorMapper_i (
		.Clk(MAX10_CLK1_50), .rst(rst), .hs(VGA_HS), .visible(visible),
		.DrawX(drawX), .DrawY(drawY), .dispRow(dispRow), .dispRowData(dispRowData),
		.pieceX(pieceX), .pieceY(pieceY), .pieceColor(pieceColor),
		.Red(VGA_R), .Green(VGA_G), .Blue(VGA_B)
	);

	// ==============================
	// score and LEDs
	// ==============================

	// score as two hex digits, decimal points dark
	hexDriver hexLow (.In0(score[3:0]), .Out0(HEX0[6:0]));
	hexDriver hexHigh (.In0(score[7:4]), .Out0(HEX1[6:0]));
	assign HEX0[7] = 1'b1;
	assign HEX1[7] = 1'b1;

	// x on 3:0, y on 8:4, game over on 9
	assign LEDR = {gameOver, pieceY, pieceX};

endmodule

// ==== tetrisTb.sv ====
// testbench for the game core top level
// frame table, board model, random keys and game over run

`timescale 1ns/1ps

module tetrisTb;

	import tetrisPkg::*;

	// ==============================
	// frame geometry
	// ==============================

	localparam int HVis = 48;
	localparam int HFp = 4;
	localparam int HSp = 8;
	localparam int HBp = 4;
	localparam int VVis = 84;
	localparam int VFp = 2;
	localparam int VSp = 2;
	localparam int VBp = 2;
	localparam int HTotal = HVis + HFp + HSp + HBp;
	localparam int VTotal = VVis + VFp + VSp + VBp;
	localparam int FrameClks = HTotal * VTotal;
	localparam int Fall = 4;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] keycode;
	logic [9:0] LEDR;
	logic [7:0] HEX0;
	logic [7:0] HEX1;
	logic VGA_HS;
	logic VGA_VS;
	logic [3:0] VGA_R;
	logic [3:0] VGA_G;
	logic [3:0] VGA_B;

	tetrisTop #(
		.HVisible(HVis), .HFront(HFp), .HSync(HSp), .HBack(HBp),
		.VVisible(VVis), .VFront(VFp), .VSync(VSp), .VBack(VBp),
		.CellShift(2), .FallDiv(Fall)
	) tetrisTop_i (
		.MAX10_CLK1_50(clk), .rst(rst), .keycode(keycode), .LEDR(LEDR),
		.HEX0(HEX0), .HEX1(HEX1), .VGA_HS(VGA_HS), .VGA_VS(VGA_VS),
		.VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	int errors = 0;

	task automatic checkVal(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ==============================
	// raster monitor
	// ==============================

	logic hsPrev;
	logic vsPrev;
	logic vsSeen;
	int cyc;
	int hsLast;
	int lineCnt;
	int pixAcc;
	int framePix;
	int frameNo = 0;

	// line period, lines per frame and lit pixels per frame
	always @(posedge clk) begin
		if (rst) begin
			hsPrev <= 1'b1;
			vsPrev <= 1'b1;
			vsSeen <= 1'b0;
			cyc <= 0;
			hsLast <= -1;
			lineCnt <= 0;
			pixAcc <= 0;
		end else begin
			cyc <= cyc + 1;
			hsPrev <= VGA_HS;
			vsPrev <= VGA_VS;
			if ({VGA_R, VGA_G, VGA_B} != 12'h000)
				pixAcc <= pixAcc + 1;
			if (hsPrev && !VGA_HS) begin
				if (hsLast >= 0)
					checkVal("VGA_HS period", cyc - hsLast, HTotal);
				hsLast <= cyc;
				lineCnt <= lineCnt + 1;
			end
			if (vsPrev && !VGA_VS) begin
				if (vsSeen)
					checkVal("lines per frame", lineCnt, VTotal);
				vsSeen <= 1'b1;
				lineCnt <= 0;
				framePix <= pixAcc;
				pixAcc <= 0;
				frameNo <= frameNo + 1;
			end
		end
	end

	// ==============================
	// board model
	// ==============================

	int board [BoardRows][BoardCols];
	int mX;
	int mY;
	int mColor;
	int mScore;
	int mFall;
	bit mOver;
	int expPix;

	// two neighbouring cells free
	// rows past the bottom count as full
	function automatic bit cellsFree(input int row, input int col);
		if (row >= BoardRows)
			return 1'b0;
		return board[row][col] == 0 && board[row][col+1] == 0;
	endfunction

	function automatic int lockedCells();
		int n;
		n = 0;
		for (int r = 0; r < BoardRows; r++)
			for (int c = 0; c < BoardCols; c++)
				if (board[r][c] != 0)
					n++;
		return n;
	endfunction

	task automatic modelReset();
		for (int r = 0; r < BoardRows; r++)
			for (int c = 0; c < BoardCols; c++)
				board[r][c] = 0;
		mX = 4;
		mY = 0;
		mColor = 1;
		mScore = 0;
		mFall = 0;
		mOver = 1'b0;
	endtask

	task automatic lockPiece();
		int r;
		bit full;
		board[mY][mX] = mColor;
		board[mY][mX+1] = mColor;
		board[mY+1][mX] = mColor;
		board[mY+1][mX+1] = mColor;
		// bottom-up scan
		// a removed row is looked at again
		r = BoardRows - 1;
		while (r >= 0) begin
			full = 1'b1;
			for (int c = 0; c < BoardCols; c++)
				if (board[r][c] == 0)
					full = 1'b0;
			if (full) begin
				mScore++;
				for (int k = r; k > 0; k--)
					for (int c = 0; c < BoardCols; c++)
						board[k][c] = board[k-1][c];
				for (int c = 0; c < BoardCols; c++)
					board[0][c] = 0;
			end else begin
				r--;
			end
		end
		mColor = (mColor == 7) ? 1 : mColor + 1;
		if (cellsFree(0, 4) && cellsFree(1, 4)) begin
			mX = 4;
			mY = 0;
		end else begin
			mOver = 1'b1;
		end
	endtask

	// frame tick with the move before gravity
	task automatic modelTick(input logic [7:0] key);
		bit due;
		if (!mOver) begin
			due = (key == KeyDrop) || (mFall == Fall - 1);
			mFall = (mFall + 1) % Fall;
			if (key == KeyLeft && mX > 0 && cellsFree(mY, mX - 1) && cellsFree(mY + 1, mX - 1))
				mX--;
			else if (key == KeyRight && mX < 8 && cellsFree(mY, mX + 1) &&
					cellsFree(mY + 1, mX + 1))
				mX++;
			if (due) begin
				if (cellsFree(mY + 2, mX))
					mY++;
				else
					lockPiece();
			end
		end
	endtask

	// active-low segments with a in bit 0 and dp off
	function automatic logic [7:0] segPattern(input logic [3:0] d);
		logic [6:0] s;
		case (d)
			4'h0: s = 7'h40;
			4'h1: s = 7'h79;
			4'h2: s = 7'h24;
			4'h3: s = 7'h30;
			4'h4: s = 7'h19;
			4'h5: s = 7'h12;
			4'h6: s = 7'h02;
			4'h7: s = 7'h78;
			4'h8: s = 7'h00;
			4'h9: s = 7'h10;
			4'hA: s = 7'h08;
			4'hB: s = 7'h03;
			4'hC: s = 7'h46;
			4'hD: s = 7'h21;
			4'hE: s = 7'h06;
			default: s = 7'h0E;
		endcase
		return {1'b1, s};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// ==============================
	// frame stepping
	// ==============================

	// starts at time zero or on a falling edge
	task automatic applyReset();
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		modelReset();
		// empty board with only the piece
		expPix = 4 * 16;
		repeat (30) @(posedge clk);
		checkVal("LEDR", int'(LEDR), 10'h004);
		checkVal("HEX0", int'(HEX0), int'(segPattern(4'h0)));
		checkVal("HEX1", int'(HEX1), int'(segPattern(4'h0)));
	endtask

	task automatic runFrame(input logic [7:0] key);
		int startNo;
		int waited;
		@(negedge clk);
		keycode = key;
		startNo = frameNo;
		waited = 0;
		while (frameNo == startNo && waited < 2 * FrameClks) begin
			@(posedge clk);
			waited++;
		end
		if (frameNo == startNo) begin
			$display("timeout: no falling edge on VGA_VS");
			$display("Verification failed");
			$finish;
		end else begin
			// frame just drawn shows the state of the previous tick
			checkVal("lit pixels", framePix, expPix);
			repeat (250) @(posedge clk);
			modelTick(key);
			checkVal("LEDR x", int'(LEDR[3:0]), mX);
			checkVal("LEDR y", int'(LEDR[8:4]), mY);
			checkVal("LEDR gameOver", int'(LEDR[9]), int'(mOver));
			checkVal("HEX0", int'(HEX0), int'(segPattern(4'(mScore))));
			checkVal("HEX1", int'(HEX1), int'(segPattern(4'(mScore >> 4))));
			// frozen piece sits on its own locked cells
			expPix = mOver ? lockedCells() * 16 : (lockedCells() + 4) * 16;
		end
	endtask

	// ==============================
	// stimulus table
	// ==============================

	typedef struct packed {
		logic [7:0] key;
		logic [7:0] count;
		logic [3:0] x;
		logic [4:0] y;
		logic over;
		logic [7:0] score;
	} stepRow_t;

	localparam int NumSteps = 22;

	// key, frames, then x, y, gameOver and score after the last frame
	localparam stepRow_t Steps [NumSteps] = '{
		'{KeyLeft, 3, 1, 0, 0, 0},
		'{KeyLeft, 1, 0, 1, 0, 0},
		'{KeyLeft, 2, 0, 1, 0, 0},
		'{KeyRight, 1, 1, 1, 0, 0},
		'{KeyRight, 1, 2, 2, 0, 0},
		'{KeyRight, 4, 6, 3, 0, 0},
		'{KeyRight, 3, 8, 3, 0, 0},
		'{KeyNone, 1, 8, 4, 0, 0},
		'{KeyRight, 1, 8, 4, 0, 0},
		'{KeyDrop, 14, 8, 18, 0, 0},
		'{KeyDrop, 1, 4, 0, 0, 0},
		'{KeyLeft, 4, 0, 1, 0, 0},
		'{KeyDrop, 17, 0, 18, 0, 0},
		'{KeyDrop, 1, 4, 0, 0, 0},
		'{KeyLeft, 2, 2, 1, 0, 0},
		'{KeyDrop, 17, 2, 18, 0, 0},
		'{KeyDrop, 1, 4, 0, 0, 0},
		'{KeyDrop, 18, 4, 18, 0, 0},
		'{KeyDrop, 1, 4, 0, 0, 0},
		'{KeyRight, 2, 6, 0, 0, 0},
		'{KeyDrop, 18, 6, 18, 0, 0},
		'{KeyDrop, 1, 4, 0, 0, 2}
	};

	initial begin
		logic [31:0] seed;
		logic [7:0] keys [4];
		int n;
		rst = 1'b1;
		keycode = KeyNone;
		keys = '{KeyNone, KeyLeft, KeyRight, KeyDrop};
		seed = 32'he86637dc;
		applyReset();

		// moves, walls, drop, lock and the two-row clear
		for (int i = 0; i < NumSteps; i++) begin
			for (int k = 0; k < Steps[i].count; k++)
				runFrame(Steps[i].key);
			checkVal("table x", int'(LEDR[3:0]), int'(Steps[i].x));
			checkVal("table y", int'(LEDR[8:4]), int'(Steps[i].y));
			checkVal("table gameOver", int'(LEDR[9]), int'(Steps[i].over));
			checkVal("table HEX0", int'(HEX0), int'(segPattern(Steps[i].score[3:0])));
			checkVal("table HEX1", int'(HEX1), int'(segPattern(Steps[i].score[7:4])));
		end

		// random keys against the model
		for (int i = 0; i < 60; i++) begin
			seed = xorshift(seed);
			runFrame(keys[seed[1:0]]);
		end

		// stack pieces in the middle until the spawn cells fill
		@(negedge clk);
		applyReset();
		n = 0;
		while (!LEDR[9] && n < 250) begin
			runFrame(KeyDrop);
			n++;
		end
		// ten pieces take 19 + 17 + ... + 1 frames
		checkVal("frames to game over", n, 100);
		checkVal("LEDR gameOver", int'(LEDR[9]), 1);
		for (int i = 0; i < 6; i++) begin
			runFrame(keys[i % 4]);
			checkVal("LEDR frozen", int'(LEDR), 10'h204);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
tetrisPkg.sv
vgaTiming.sv
boardRam.sv
gameLogic.sv
colorMapper.sv
hexDriver.sv
tetrisTop.sv
tetrisTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tetrisTb -o tetrisSim \
	&& ./obj_dir/tetrisSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || true
grep -q "Verification passed" sim.log && exit 0 || exit 1
